// File: all.f
rtl/tdc_readout_pkg.sv
rtl/apb_regs.sv
rtl/acq_control.sv
rtl/sample_fifo.sv
rtl/word_serializer.sv
rtl/uart_tx.sv
rtl/tdc_readout_top.sv
verification/uart_rx_model.sv
verification/tb_tdc_readout.sv

// File: verification/tb_tdc_readout.sv
// testbench for the tdc readout
// table-driven apb stages, lfsr samples, uart bytes checked against a word queue

module tb_tdc_readout
    import tdc_readout_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------------------------------------------
    // constants and types
    // ------------------------------------------------------------------
    localparam int          FIFO_DEPTH  = 16;
    localparam int          BAUD_RESET  = 8;
    localparam int          NUM_ROWS    = 23;
    localparam int          APB_LIMIT   = 16;
    localparam int          STATE_POLLS = 10000;
    localparam int          RX_LIMIT    = 2000;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    typedef enum logic [2:0] {
        OP_WR,
        OP_RD,
        OP_SEND,
        OP_WAIT_ST,
        OP_PINS,
        OP_RX
    } op_t;

    typedef struct packed {
        op_t         op;
        apb_addr_t   addr;
        logic [31:0] data;
        logic [31:0] expected;
        logic [7:0]  count;
    } row_t;

    logic       clkWizard;
    logic       finish_mem_reset;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic       sample_valid;
    sample_t    sample_data;
    logic       tx;
    logic       led_writing;
    logic       led_reading;
    baud_div_t  rx_baud;
    int         rx_frame_errors;

    row_t        stim [NUM_ROWS];
    // words the fifo should hold in order
    sample_t     expect_q [$];
    acq_state_t  tb_stage;
    logic [31:0] lfsr_state;
    int          errors;
    int          timeouts;

    tdc_readout_top #(
        .FIFO_DEPTH       (FIFO_DEPTH),
        .DEFAULT_BAUD_DIV (BAUD_RESET)
    ) DUT (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .apb_req          (apb_req),
        .apb_rsp          (apb_rsp),
        .sample_valid     (sample_valid),
        .sample_data      (sample_data),
        .tx               (tx),
        .led_writing      (led_writing),
        .led_reading      (led_reading)
    );

    uart_rx_model u_rx (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .tx               (tx),
        .baud_div         (rx_baud),
        .frame_errors     (rx_frame_errors)
    );

    // 4 ns period
    always #2 clkWizard = ~clkWizard;

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    // drive point is 1 ns after the rising edge
    task automatic step();
        @(posedge clkWizard);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, expected);
        end
    endtask

    // one galois step for each bit taken
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    task automatic next_sample(output sample_t word);
        for (int i = 0; i < 32; i++) begin
            word[i]    = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // one apb transfer of setup then access
    task automatic apb_access(input logic write, input apb_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waited;
        waited          = 0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        step();
        apb_req.penable = 1'b1;
        // response sampled mid-cycle
        @(negedge clkWizard);
        while (!apb_rsp.pready && waited < APB_LIMIT) begin
            @(negedge clkWizard);
            waited++;
        end
        if (!apb_rsp.pready) begin
            timeouts++;
            $display("timeout: apb slave never raised pready at address 0x%02h", addr);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        step();
        apb_req = '0;
    endtask

    task automatic send_samples(input int n);
        sample_t word;
        for (int i = 0; i < n; i++) begin
            next_sample(word);
            sample_valid = 1'b1;
            sample_data  = word;
            // stored only in the writing stage and while not full
            if (tb_stage == ACQ_WRITE && expect_q.size() < FIFO_DEPTH) begin
                expect_q.push_back(word);
            end
            step();
        end
        sample_valid = 1'b0;
    endtask

    // poll status until the stage field matches
    task automatic wait_state(input acq_state_t target);
        logic [31:0] rdata;
        logic        err;
        int          polls;
        polls = 0;
        apb_access(1'b0, REG_STATUS, '0, rdata, err);
        while (rdata[1:0] != target && polls < STATE_POLLS) begin
            apb_access(1'b0, REG_STATUS, '0, rdata, err);
            polls++;
        end
        if (rdata[1:0] != target) begin
            timeouts++;
            $display("timeout: stage %0d was never reached", target);
        end else begin
            tb_stage = target;
        end
    endtask

    // expected and mask are {tx, led_writing, led_reading}
    task automatic check_pins(input logic [2:0] expected, input logic [2:0] mask);
        @(negedge clkWizard);
        if (mask[2]) begin
            check_value("tx", tx, expected[2]);
        end
        if (mask[1]) begin
            check_value("led_writing", led_writing, expected[1]);
        end
        if (mask[0]) begin
            check_value("led_reading", led_reading, expected[0]);
        end
        step();
    endtask

    // received bytes against the stored words in lsb-first order
    task automatic check_rx();
        int      n;
        int      tries;
        byte_t   got;
        sample_t word;
        n     = expect_q.size() * 4;
        tries = 0;
        while (u_rx.byte_q.size() < n && tries < RX_LIMIT) begin
            step();
            tries++;
        end
        if (u_rx.byte_q.size() < n) begin
            timeouts++;
            $display("timeout: uart receiver got %0d of %0d bytes", u_rx.byte_q.size(), n);
        end
        check_value("rx_byte_count", u_rx.byte_q.size(), n);
        check_value("rx_frame_errors", rx_frame_errors, 0);
        while (expect_q.size() > 0) begin
            word = expect_q.pop_front();
            for (int b = 0; b < 4; b++) begin
                if (u_rx.byte_q.size() > 0) begin
                    got = u_rx.byte_q.pop_front();
                    check_value("rx_byte", got, word[b*8 +: 8]);
                end
            end
        end
        u_rx.byte_q.delete();
    endtask

    task automatic run_row(input row_t r);
        logic [31:0] rdata;
        logic        err;
        case (r.op)
            OP_WR: begin
                apb_access(1'b1, r.addr, r.data, rdata, err);
                // receiver follows the programmed divisor
                if (r.addr == REG_BAUD) begin
                    rx_baud = r.data[15:0];
                end
            end
            OP_RD: begin
                // data bit 0 holds the expected pslverr
                apb_access(1'b0, r.addr, '0, rdata, err);
                check_value($sformatf("prdata[0x%02h]", r.addr), rdata, r.expected);
                check_value($sformatf("pslverr[0x%02h]", r.addr), err, r.data[0]);
            end
            OP_SEND:    send_samples(r.count);
            OP_WAIT_ST: wait_state(acq_state_t'(r.data[1:0]));
            // data is the mask of pins to compare
            OP_PINS:    check_pins(r.expected[2:0], r.data[2:0]);
            OP_RX:      check_rx();
            default: begin
                errors++;
                $display("unknown table operation %0d", r.op);
            end
        endcase
    endtask

    // ------------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------------
    task automatic load_table();
        // reset values
        stim[0]  = '{OP_PINS,    8'h00,      32'h7,  32'h4,          8'd0};
        stim[1]  = '{OP_RD,      REG_STATUS, 32'h0,  32'h0000_0004,  8'd0};
        // baud readback and unmapped address
        stim[2]  = '{OP_WR,      REG_BAUD,   32'h6,  32'h0,          8'd0};
        stim[3]  = '{OP_RD,      REG_BAUD,   32'h0,  32'h0000_0006,  8'd0};
        stim[4]  = '{OP_RD,      8'h0c,      32'h1,  32'h0,          8'd0};
        // samples in wait are lost
        stim[5]  = '{OP_SEND,    8'h00,      32'h0,  32'h0,          8'd4};
        stim[6]  = '{OP_RD,      REG_STATUS, 32'h0,  32'h0000_0004,  8'd0};
        // writing stage
        stim[7]  = '{OP_WR,      REG_CTRL,   32'h1,  32'h0,          8'd0};
        stim[8]  = '{OP_WAIT_ST, 8'h00,      32'h1,  32'h0,          8'd0};
        stim[9]  = '{OP_SEND,    8'h00,      32'h0,  32'h0,          8'd5};
        stim[10] = '{OP_RD,      REG_STATUS, 32'h0,  32'h0005_0001,  8'd0};
        stim[11] = '{OP_PINS,    8'h00,      32'h7,  32'h6,          8'd0};
        // overflow and write-one-to-clear
        stim[12] = '{OP_SEND,    8'h00,      32'h0,  32'h0,          8'(FIFO_DEPTH + 3)};
        stim[13] = '{OP_RD,      REG_STATUS, 32'h0,  32'h0010_0019,  8'd0};
        stim[14] = '{OP_WR,      REG_STATUS, 32'h10, 32'h0,          8'd0};
        stim[15] = '{OP_RD,      REG_STATUS, 32'h0,  32'h0010_0009,  8'd0};
        // readout
        stim[16] = '{OP_WR,      REG_CTRL,   32'h2,  32'h0,          8'd0};
        stim[17] = '{OP_WAIT_ST, 8'h00,      32'h2,  32'h0,          8'd0};
        // tx is busy here so only the leds
        stim[18] = '{OP_PINS,    8'h00,      32'h3,  32'h1,          8'd0};
        stim[19] = '{OP_WAIT_ST, 8'h00,      32'h0,  32'h0,          8'd0};
        stim[20] = '{OP_RX,      8'h00,      32'h0,  32'h0,          8'd0};
        stim[21] = '{OP_RD,      REG_STATUS, 32'h0,  32'h0000_0004,  8'd0};
        stim[22] = '{OP_PINS,    8'h00,      32'h7,  32'h4,          8'd0};
    endtask

    initial begin
        clkWizard        = 1'b0;
        finish_mem_reset = 1'b1;
        apb_req          = '0;
        sample_valid     = 1'b0;
        sample_data      = '0;
        rx_baud          = baud_div_t'(BAUD_RESET);
        lfsr_state       = 32'hc980;
        tb_stage         = ACQ_WAIT;
        errors           = 0;
        timeouts         = 0;
        load_table();
        // reset for 3 cycles
        repeat (3) @(posedge clkWizard);
        #1;
        finish_mem_reset = 1'b0;
        step();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(stim[i]);
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verification/uart_rx_model.sv
// uart 8n1 receiver model for the testbench
// samples the line mid-bit and queues the decoded bytes

module uart_rx_model
    import tdc_readout_pkg::*;
(
    input  logic      clkWizard,
    input  logic      finish_mem_reset,
    input  logic      tx,
    input  baud_div_t baud_div,
    output int        frame_errors
);

    timeunit 1ns;
    timeprecision 1ps;

    // decoded bytes, oldest first
    byte_t byte_q [$];
    int    div;
    byte_t data;

    initial frame_errors = 0;

    always begin
        @(posedge clkWizard);
        // first low sample after idle marks a start bit
        if (!finish_mem_reset && tx === 1'b0) begin
            div = baud_div;
            // to the middle of the start bit
            repeat (div / 2) @(posedge clkWizard);
            if (tx !== 1'b0) begin
                frame_errors++;
                $display("uart model: start bit did not stay low until mid-bit");
            end else begin
                // data bits, lsb first
                for (int i = 0; i < 8; i++) begin
                    repeat (div) @(posedge clkWizard);
                    data[i] = tx;
                end
                repeat (div) @(posedge clkWizard);
                if (tx !== 1'b1) begin
                    frame_errors++;
                    $display("uart model: stop bit was low, byte 0x%02h kept anyway", data);
                end
                byte_q.push_back(data);
            end
        end
    end

endmodule

// File: rtl/tdc_readout_top.sv
// tdc readout top level
// apb registers, stage control, sample fifo and uart readout

module tdc_readout_top
    import tdc_readout_pkg::*;
#(
    parameter int FIFO_DEPTH       = 16,
    parameter int DEFAULT_BAUD_DIV = 8
) (
    input  logic     clkWizard,
    input  logic     finish_mem_reset,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    input  logic     sample_valid,
    input  sample_t  sample_data,
    output logic     tx,
    output logic     led_writing,
    output logic     led_reading
);

    // ------------------------------------------------------------------
    // connecting wires
    // ------------------------------------------------------------------
    acq_cmd_t    cmd;
    acq_status_t status;
    baud_div_t   baud_div;
    logic        wr_allow;
    logic        rd_allow;
    logic        fifo_push;
    logic        fifo_pop;
    logic        fifo_empty;
    logic        fifo_full;
    fifo_count_t fifo_count;
    sample_t     fifo_data;
    logic        overflow_pulse;
    logic        ser_busy;
    logic        tx_valid;
    logic        tx_ready;
    byte_t       tx_byte;

    // samples only taken in the writing stage
    assign fifo_push = sample_valid && wr_allow;

    apb_regs #(
        .DEFAULT_BAUD_DIV (DEFAULT_BAUD_DIV)
    ) u_apb_regs (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .apb_req          (apb_req),
        .apb_rsp          (apb_rsp),
        .status           (status),
        .overflow_pulse   (overflow_pulse),
        .cmd              (cmd),
        .baud_div         (baud_div)
    );

    acq_control u_acq_control (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .cmd              (cmd),
        .fifo_count       (fifo_count),
        .fifo_empty       (fifo_empty),
        .fifo_full        (fifo_full),
        .ser_busy         (ser_busy),
        .status           (status),
        .wr_allow         (wr_allow),
        .rd_allow         (rd_allow),
        .led_writing      (led_writing),
        .led_reading      (led_reading)
    );

    sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_sample_fifo (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .push             (fifo_push),
        .push_data        (sample_data),
        .pop              (fifo_pop),
        .pop_data         (fifo_data),
        .empty            (fifo_empty),
        .full             (fifo_full),
        .count            (fifo_count),
        .overflow_pulse   (overflow_pulse)
    );

    word_serializer u_word_serializer (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .rd_allow         (rd_allow),
        .fifo_empty       (fifo_empty),
        .fifo_data        (fifo_data),
        .tx_ready         (tx_ready),
        .fifo_pop         (fifo_pop),
        .tx_valid         (tx_valid),
        .tx_byte          (tx_byte),
        .ser_busy         (ser_busy)
    );

    uart_tx u_uart_tx (
        .clkWizard        (clkWizard),
        .finish_mem_reset (finish_mem_reset),
        .baud_div         (baud_div),
        .tx_valid         (tx_valid),
        .tx_byte          (tx_byte),
        .tx_ready         (tx_ready),
        .tx               (tx)
    );

endmodule

// File: rtl/uart_tx.sv
// uart 8n1 transmitter
// own baud counter, lsb first, valid/ready byte input

module uart_tx
    import tdc_readout_pkg::*;
(
    input  logic      clkWizard,
    input  logic      finish_mem_reset,
    input  baud_div_t baud_div,
    input  logic      tx_valid,
    input  byte_t     tx_byte,
    output logic      tx_ready,
    output logic      tx
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t state;
    baud_div_t baud_cnt;
    logic [2:0] bit_cnt;
    byte_t     shift_q;
    logic      bit_end;

    assign tx_ready = (state == TX_IDLE);
    // last cycle of the current bit
    assign bit_end  = (baud_cnt == '0);

    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            state    <= TX_IDLE;
            tx       <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= 3'd0;
        end else begin
            // counter reloads on every bit
            if (state != TX_IDLE) begin
                baud_cnt <= bit_end ? baud_div - 1'b1 : baud_cnt - 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    tx <= 1'b1;
                    if (tx_valid) begin
                        state    <= TX_START;
                        tx       <= 1'b0;
                        baud_cnt <= baud_div - 1'b1;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        tx      <= shift_q[0];
                        bit_cnt <= 3'd0;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            state <= TX_STOP;
                            tx    <= 1'b1;
                        end else begin
                            tx      <= shift_q[1];
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                end
                TX_STOP: begin
                    // ready comes back the cycle after this
                    if (bit_end) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // shift register, loaded on accept, moves on each data bit
    always_ff @(posedge clkWizard) begin
        if (tx_ready && tx_valid) begin
            shift_q <= tx_byte;
        end else if (state == TX_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// File: rtl/word_serializer.sv
// word serializer
// pops one stored word and feeds its four bytes to the uart, lsb first

module word_serializer
    import tdc_readout_pkg::*;
(
    input  logic    clkWizard,
    input  logic    finish_mem_reset,
    input  logic    rd_allow,
    input  logic    fifo_empty,
    input  sample_t fifo_data,
    input  logic    tx_ready,
    output logic    fifo_pop,
    output logic    tx_valid,
    output byte_t   tx_byte,
    output logic    ser_busy
);

    logic       active;
    logic [1:0] byte_idx;
    sample_t    word_q;

    // new word only when idle and in the read stage
    assign fifo_pop = rd_allow && !active && !fifo_empty;

    assign tx_valid = active;
    assign tx_byte  = word_q[byte_idx*8 +: 8];

    // busy also covers the frame still on the line
    assign ser_busy = active || !tx_ready;

    // payload latch
    always_ff @(posedge clkWizard) begin
        if (fifo_pop) begin
            word_q <= fifo_data;
        end
    end

    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            active   <= 1'b0;
            byte_idx <= 2'd0;
        end else if (fifo_pop) begin
            active   <= 1'b1;
            byte_idx <= 2'd0;
        end else if (tx_valid && tx_ready) begin
            // last byte accepted, back to idle
            if (byte_idx == 2'd3) begin
                active <= 1'b0;
            end
            byte_idx <= byte_idx + 2'd1;
        end
    end

    // byte held under back-pressure
    a_byte_stable: assert property (
        @(posedge clkWizard) disable iff (finish_mem_reset)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_byte))
    );

endmodule

// File: rtl/sample_fifo.sv
// sample fifo, single clock, show-ahead output
// drops pushes when full and flags them

module sample_fifo
    import tdc_readout_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic        clkWizard,
    input  logic        finish_mem_reset,
    input  logic        push,
    input  sample_t     push_data,
    input  logic        pop,
    output sample_t     pop_data,
    output logic        empty,
    output logic        full,
    output fifo_count_t count,
    output logic        overflow_pulse
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    sample_t         mem [FIFO_DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic            do_push;
    logic            do_pop;

    assign empty   = (count == '0);
    assign full    = (count == fifo_count_t'(FIFO_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head word always on the output
    assign pop_data = mem[rd_ptr];

    // storage, no reset
    always_ff @(posedge clkWizard) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // ------------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------------
    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            overflow_pulse <= 1'b0;
        end else begin
            // dropped sample, one pulse per lost push
            overflow_pulse <= push && full;
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_count_bounded: assert property (
        @(posedge clkWizard) disable iff (finish_mem_reset)
        count <= fifo_count_t'(FIFO_DEPTH)
    );

endmodule

// File: rtl/acq_control.sv
// acquisition stage controller
// wait / write / read stages, gates fifo writes and readout

module acq_control
    import tdc_readout_pkg::*;
(
    input  logic        clkWizard,
    input  logic        finish_mem_reset,
    input  acq_cmd_t    cmd,
    input  fifo_count_t fifo_count,
    input  logic        fifo_empty,
    input  logic        fifo_full,
    input  logic        ser_busy,
    output acq_status_t status,
    output logic        wr_allow,
    output logic        rd_allow,
    output logic        led_writing,
    output logic        led_reading
);

    acq_state_t state;
    acq_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            ACQ_WAIT: begin
                if (cmd.start_write) begin
                    state_next = ACQ_WRITE;
                end else if (cmd.start_read) begin
                    state_next = ACQ_READ;
                end
            end
            ACQ_WRITE: begin
                if (cmd.stop) begin
                    state_next = ACQ_WAIT;
                end else if (cmd.start_read) begin
                    state_next = ACQ_READ;
                end
            end
            ACQ_READ: begin
                // readout done once fifo drained and last frame out
                if (cmd.stop || (fifo_empty && !ser_busy)) begin
                    state_next = ACQ_WAIT;
                end
            end
            default: state_next = ACQ_WAIT;
        endcase
    end

    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            state       <= ACQ_WAIT;
            led_writing <= 1'b0;
            led_reading <= 1'b0;
        end else begin
            state       <= state_next;
            // leds follow the stage register
            led_writing <= (state_next == ACQ_WRITE);
            led_reading <= (state_next == ACQ_READ);
        end
    end

    assign wr_allow = (state == ACQ_WRITE);
    assign rd_allow = (state == ACQ_READ);

    assign status.state      = state;
    assign status.fifo_count = fifo_count;
    assign status.fifo_empty = fifo_empty;
    assign status.fifo_full  = fifo_full;

    // writing and readout never overlap
    a_allow_exclusive: assert property (
        @(posedge clkWizard) disable iff (finish_mem_reset)
        !(wr_allow && rd_allow)
    );

endmodule

// File: rtl/apb_regs.sv
// apb register block for the tdc readout
// command pulses, status word, baud divisor and sticky overflow

module apb_regs
    import tdc_readout_pkg::*;
#(
    parameter int DEFAULT_BAUD_DIV = 8
) (
    input  logic        clkWizard,
    input  logic        finish_mem_reset,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    input  acq_status_t status,
    input  logic        overflow_pulse,
    output acq_cmd_t    cmd,
    output baud_div_t   baud_div
);

    logic        access;
    logic        wr_access;
    logic        mapped;
    logic        overflow;
    logic [31:0] status_word;

    // access phase, no wait states
    assign access    = apb_req.psel && apb_req.penable;
    assign wr_access = access && apb_req.pwrite && mapped;

    assign mapped = (apb_req.paddr == REG_CTRL) ||
                    (apb_req.paddr == REG_STATUS) ||
                    (apb_req.paddr == REG_BAUD);

    // status layout: count 26:16, ovf 4, full 3, empty 2, state 1:0
    assign status_word = {5'd0, status.fifo_count, 11'd0, overflow,
                          status.fifo_full, status.fifo_empty, status.state};

    // ------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------
    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && !mapped;
        apb_rsp.prdata  = '0;
        case (apb_req.paddr)
            REG_STATUS: apb_rsp.prdata = status_word;
            REG_BAUD:   apb_rsp.prdata = {16'd0, baud_div};
            // ctrl is write-only and reads zero
            default:    apb_rsp.prdata = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------
    always_ff @(posedge clkWizard) begin
        if (finish_mem_reset) begin
            cmd      <= '0;
            baud_div <= baud_div_t'(DEFAULT_BAUD_DIV);
            overflow <= 1'b0;
        end else begin
            // pulses last one cycle only
            cmd <= '0;
            if (wr_access && apb_req.paddr == REG_CTRL) begin
                cmd.start_write <= apb_req.pwdata[0];
                cmd.start_read  <= apb_req.pwdata[1];
                cmd.stop        <= apb_req.pwdata[2];
            end
            if (wr_access && apb_req.paddr == REG_BAUD) begin
                baud_div <= apb_req.pwdata[15:0];
            end
            // sticky flag, a new drop wins over the clear
            if (overflow_pulse) begin
                overflow <= 1'b1;
            end else if (wr_access && apb_req.paddr == REG_STATUS &&
                         apb_req.pwdata[4]) begin
                overflow <= 1'b0;
            end
        end
    end

    // enable only inside a selected transfer
    a_penable_needs_psel: assert property (
        @(posedge clkWizard) disable iff (finish_mem_reset)
        apb_req.penable |-> apb_req.psel
    );

endmodule

// File: rtl/tdc_readout_pkg.sv
// tdc readout shared definitions
// widths, stage encoding, apb bundles and register map

package tdc_readout_pkg;

    // ------------------------------------------------------------------
    // widths with a meaning
    // ------------------------------------------------------------------
    // one tdc timestamp word
    typedef logic [31:0] sample_t;
    // one uart byte
    typedef logic [7:0]  byte_t;
    // clock cycles per uart bit
    typedef logic [15:0] baud_div_t;
    // fifo occupancy for up to 1024 entries
    typedef logic [10:0] fifo_count_t;
    // apb byte address
    typedef logic [7:0]  apb_addr_t;

    // acquisition stages
    typedef enum logic [1:0] {
        ACQ_WAIT  = 2'd0,
        ACQ_WRITE = 2'd1,
        ACQ_READ  = 2'd2
    } acq_state_t;

    // ------------------------------------------------------------------
    // bundles
    // ------------------------------------------------------------------
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        apb_addr_t   paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // single-cycle command pulses from the ctrl register
    typedef struct packed {
        logic start_write;
        logic start_read;
        logic stop;
    } acq_cmd_t;

    typedef struct packed {
        acq_state_t  state;
        fifo_count_t fifo_count;
        logic        fifo_empty;
        logic        fifo_full;
    } acq_status_t;

    // register map
    localparam apb_addr_t REG_CTRL   = 8'h00;
    localparam apb_addr_t REG_STATUS = 8'h04;
    localparam apb_addr_t REG_BAUD   = 8'h08;

endpackage
